/* verilog.f */
+incdir+include
rtl/frv_timer_pkg.sv
rtl/frv_mmio_ingress.sv
rtl/frv_req_fifo.sv
rtl/frv_counters.sv
rtl/frv_timer_subsys.sv
verif/tb_frv_timer_subsys.sv

/* Bender.yml */
package:
  name: frv_timer

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - rtl/frv_timer_pkg.sv
      - rtl/frv_mmio_ingress.sv
      - rtl/frv_req_fifo.sv
      - rtl/frv_counters.sv
      - rtl/frv_timer_subsys.sv
      - target: test
        files:
          - verif/tb_frv_timer_subsys.sv

/* verif/tb_frv_timer_subsys.sv */
// Testbench for the timer subsystem
// Clock and reset, host request and credit stimulus, reference model,
// and the checking assertions

`timescale 1ns/1ps

`include "frv_timer_defs.svh"

module tb_frv_timer_subsys;

    localparam int REQ_DEPTH  = `FRV_REQ_FIFO_DEPTH;
    localparam int RSP_MAX    = `FRV_RSP_CREDITS_MAX;
    localparam int WAIT_LIMIT = 200;        // Cycles per wait loop

    localparam frv_timer_pkg::mmio_addr_t BASE = `FRV_MMIO_BASE_ADDR;

    logic                      g_clk;
    logic                      g_resetn;
    logic                      host_req_valid;
    logic                      host_req_wen;
    frv_timer_pkg::mmio_addr_t host_req_addr;
    frv_timer_pkg::mmio_data_t host_req_wdata;
    logic                      host_req_credit;
    logic                      host_rsp_credit;
    logic                      rsp_valid;
    frv_timer_pkg::mmio_data_t rsp_rdata;
    logic                      rsp_error;
    logic                      instr_ret;
    logic                      inhibit_cy;
    logic                      inhibit_tm;
    logic                      inhibit_ir;
    logic                      timer_interrupt;
    frv_timer_pkg::ctr_t       ctr_time;
    frv_timer_pkg::ctr_t       ctr_cycle;
    frv_timer_pkg::ctr_t       ctr_instret;

    // Host bookkeeping and reference model
    int                        req_credits;
    int                        rsp_outstanding;    // Granted slots not yet answered
    logic [32:0]               exp_q[$];           // {error, rdata} in request order
    logic                      exp_any;
    logic                      exp_err;
    frv_timer_pkg::mmio_data_t exp_rdata;
    frv_timer_pkg::ctr_t       mtime_m;
    frv_timer_pkg::ctr_t       mtimecmp_m;
    frv_timer_pkg::ctr_t       cy_model;
    frv_timer_pkg::ctr_t       ir_model;
    logic [33:0]               tm_wr_q[$];         // {mtime write, high half, wdata}
    logic [33:0]               tm_wr;
    frv_timer_pkg::ctr_t       tm_model;           // mtime as the DUT holds it
    frv_timer_pkg::ctr_t       tm_last;            // mtime one edge earlier
    frv_timer_pkg::ctr_t       tm_nxt;
    logic                      grant_en;
    logic                      irq_quiet;          // Interrupt must stay low
    logic [7:0]                bg_cnt;
    int                        value_errs;
    int                        proto_errs;
    int                        timeouts;
    int                        seed;

    frv_timer_subsys i_frv_timer_subsys (
        .g_clk           (g_clk),
        .g_resetn        (g_resetn),
        .host_req_valid  (host_req_valid),
        .host_req_wen    (host_req_wen),
        .host_req_addr   (host_req_addr),
        .host_req_wdata  (host_req_wdata),
        .host_req_credit (host_req_credit),
        .host_rsp_credit (host_rsp_credit),
        .rsp_valid       (rsp_valid),
        .rsp_rdata       (rsp_rdata),
        .rsp_error       (rsp_error),
        .instr_ret       (instr_ret),
        .inhibit_cy      (inhibit_cy),
        .inhibit_tm      (inhibit_tm),
        .inhibit_ir      (inhibit_ir),
        .timer_interrupt (timer_interrupt),
        .ctr_time        (ctr_time),
        .ctr_cycle       (ctr_cycle),
        .ctr_instret     (ctr_instret)
    );

    initial begin
        g_clk = 1'b0;
        forever #4 g_clk = ~g_clk;
    end

    // Outside the 4 KiB window, or past the four word registers
    function automatic logic addr_faults(input frv_timer_pkg::mmio_addr_t addr);
        return ((addr & `FRV_MMIO_BASE_MASK) != `FRV_MMIO_BASE_ADDR) || (addr[11:0] >= 12'd16);
    endfunction

    function automatic frv_timer_pkg::mmio_data_t model_word(input frv_timer_pkg::reg_sel_t sel);
        case (sel)
            2'd0:    return mtime_m[31:0];
            2'd1:    return mtime_m[63:32];
            2'd2:    return mtimecmp_m[31:0];
            default: return mtimecmp_m[63:32];
        endcase
    endfunction

    always @(posedge g_clk) begin
        if (!g_resetn) begin
            exp_q.delete();
            tm_wr_q.delete();
            exp_any         <= 1'b0;
            exp_err         <= 1'b0;
            exp_rdata       <= '0;
            req_credits     <= REQ_DEPTH;
            rsp_outstanding <= 0;
            host_rsp_credit <= 1'b0;
            mtime_m         <= '0;
            mtimecmp_m      <= `FRV_MTIMECMP_RESET;
            cy_model        <= '0;
            ir_model        <= '0;
            tm_model        <= '0;
            tm_last         <= '0;
        end else begin
            // Grant a slot only for a request that still waits for one
            host_rsp_credit <= grant_en
                && (rsp_outstanding + int'(host_rsp_credit) < RSP_MAX)
                && (rsp_outstanding + int'(host_rsp_credit) < exp_q.size());
            // A response shows which pop one edge ago wrote mtime
            tm_nxt = tm_model;
            if (rsp_valid && exp_q.size() != 0) begin
                void'(exp_q.pop_front());
                tm_wr = tm_wr_q.pop_front();
                if (tm_wr[33] && tm_wr[32]) begin
                    tm_nxt = {tm_wr[31:0], tm_last[31:0]};
                end else if (tm_wr[33]) begin
                    tm_nxt = {tm_last[63:32], tm_wr[31:0]};
                end
            end
            tm_last  <= tm_nxt;
            tm_model <= tm_nxt + 64'(!inhibit_tm);   // A write wins over the count
            if (host_req_valid) begin
                tm_wr_q.push_back({host_req_wen && !host_req_addr[3] && !addr_faults(host_req_addr),
                                   host_req_addr[2], host_req_wdata});
                if (addr_faults(host_req_addr)) begin
                    exp_q.push_back({1'b1, 32'h0});
                end else if (host_req_wen) begin
                    exp_q.push_back({1'b0, 32'h0});
                    case (host_req_addr[3:2])
                        2'd0:    mtime_m[31:0]     <= host_req_wdata;
                        2'd1:    mtime_m[63:32]    <= host_req_wdata;
                        2'd2:    mtimecmp_m[31:0]  <= host_req_wdata;
                        default: mtimecmp_m[63:32] <= host_req_wdata;
                    endcase
                end else begin
                    exp_q.push_back({1'b0, model_word(host_req_addr[3:2])});
                end
            end
            exp_any <= exp_q.size() != 0;
            if (exp_q.size() != 0) begin
                exp_err   <= exp_q[0][32];
                exp_rdata <= exp_q[0][31:0];
            end
            req_credits     <= req_credits - int'(host_req_valid) + int'(host_req_credit);
            rsp_outstanding <= rsp_outstanding + int'(host_rsp_credit) - int'(rsp_valid);
            if (!inhibit_cy) begin
                cy_model <= cy_model + 64'd1;
            end
            if (instr_ret && !inhibit_ir) begin
                ir_model <= ir_model + 64'd1;
            end
        end
    end

    // Retire and inhibit patterns from a free running count
    always @(posedge g_clk) begin
        bg_cnt     <= bg_cnt + 8'd1;
        instr_ret  <= bg_cnt[0] ^ bg_cnt[2];
        inhibit_ir <= bg_cnt[5:3] == 3'd3;
        inhibit_cy <= bg_cnt[6:4] == 3'd5;
    end

    assert property (@(posedge g_clk) disable iff (!g_resetn) ctr_cycle == cy_model)
    else begin
        value_errs++;
        $display("ERROR at %0t: ctr_cycle = %0d, expected %0d", $time,
                 $sampled(ctr_cycle), $sampled(cy_model));
    end

    assert property (@(posedge g_clk) disable iff (!g_resetn) ctr_instret == ir_model)
    else begin
        value_errs++;
        $display("ERROR at %0t: ctr_instret = %0d, expected %0d", $time,
                 $sampled(ctr_instret), $sampled(ir_model));
    end

    // Right after a pop the model has not yet seen a possible mtime write
    assert property (@(posedge g_clk) disable iff (!g_resetn)
        !rsp_valid |-> ctr_time == tm_model)
    else begin
        value_errs++;
        $display("ERROR at %0t: ctr_time = %0d, expected %0d", $time,
                 $sampled(ctr_time), $sampled(tm_model));
    end

    assert property (@(posedge g_clk) disable iff (!g_resetn) rsp_valid |-> exp_any)
    else begin
        proto_errs++;
        $display("A response arrived with no request outstanding at %0t", $time);
    end

    assert property (@(posedge g_clk) disable iff (!g_resetn)
        rsp_valid && exp_any |-> rsp_rdata == exp_rdata)
    else begin
        value_errs++;
        $display("ERROR at %0t: rsp_rdata = %h, expected %h", $time,
                 $sampled(rsp_rdata), $sampled(exp_rdata));
    end

    assert property (@(posedge g_clk) disable iff (!g_resetn)
        rsp_valid && exp_any |-> rsp_error == exp_err)
    else begin
        value_errs++;
        $display("ERROR at %0t: rsp_error = %b, expected %b", $time,
                 $sampled(rsp_error), $sampled(exp_err));
    end

    assert property (@(posedge g_clk) disable iff (!g_resetn) rsp_valid |-> rsp_outstanding > 0)
    else begin
        proto_errs++;
        $display("A response arrived without a granted response credit at %0t", $time);
    end

    // One request credit comes back with each response
    assert property (@(posedge g_clk) disable iff (!g_resetn) host_req_credit == rsp_valid)
    else begin
        value_errs++;
        $display("ERROR at %0t: host_req_credit = %b, expected %b", $time,
                 $sampled(host_req_credit), $sampled(rsp_valid));
    end

    assert property (@(posedge g_clk) disable iff (!g_resetn)
        req_credits >= 0 && req_credits <= REQ_DEPTH)
    else begin
        proto_errs++;
        $display("Host request credits left their range (%0d) at %0t",
                 $sampled(req_credits), $time);
    end

    assert property (@(posedge g_clk) disable iff (!g_resetn) irq_quiet |-> !timer_interrupt)
    else begin
        proto_errs++;
        $display("timer_interrupt went high while mtime was below mtimecmp at %0t", $time);
    end

    assert property (@(posedge g_clk)
        !g_resetn |=> !rsp_valid && !host_req_credit && !timer_interrupt)
    else begin
        proto_errs++;
        $display("Outputs were not cleared by reset at %0t", $time);
    end

    // After a timeout every later wait returns at once
    task automatic report_timeout(input string what);
        timeouts++;
        $display("Timed out waiting for %s at %0t", what, $time);
    endtask

    task automatic send_req(input logic wen, input frv_timer_pkg::mmio_addr_t addr,
                            input frv_timer_pkg::mmio_data_t wdata);
        int waited;
        waited = 0;
        @(posedge g_clk);
        // Last cycle's request is not yet counted in req_credits
        while (req_credits - int'(host_req_valid) <= 0 && timeouts == 0) begin
            host_req_valid <= 1'b0;
            waited++;
            if (waited > WAIT_LIMIT) begin
                report_timeout("a request credit");
            end
            @(posedge g_clk);
        end
        host_req_valid <= timeouts == 0;
        host_req_wen   <= wen;
        host_req_addr  <= addr;
        host_req_wdata <= wdata;
    endtask

    task automatic idle_cycle();
        @(posedge g_clk);
        host_req_valid <= 1'b0;
    endtask

    task automatic random_burst(input int count);
        logic [31:0]               r;
        frv_timer_pkg::mmio_addr_t addr;
        for (int i = 0; i < count; i++) begin
            r    = $random(seed);
            addr = BASE + {r[1:0], 2'b00};
            if (r[6:4] == 3'd0) begin
                addr = addr + 32'h10;          // Past the four registers
            end else if (r[6:4] == 3'd1) begin
                addr = addr + 32'h1000;        // Next 4 KiB page
            end
            send_req(r[2], addr, $random(seed));
            if (r[3]) begin
                idle_cycle();
            end
        end
    endtask

    task automatic drain_responses();
        int waited;
        waited = 0;
        @(posedge g_clk);
        host_req_valid <= 1'b0;
        while ((exp_any || host_req_valid) && timeouts == 0) begin
            waited++;
            if (waited > WAIT_LIMIT) begin
                report_timeout("outstanding responses");
            end
            @(posedge g_clk);
        end
    endtask

    task automatic wait_for_irq();
        int waited;
        waited = 0;
        @(posedge g_clk);
        while (!timer_interrupt && timeouts == 0) begin
            waited++;
            if (waited > WAIT_LIMIT) begin
                report_timeout("timer_interrupt");
            end
            @(posedge g_clk);
        end
    endtask

    initial begin
        seed            = 32'h7407;
        value_errs      = 0;
        proto_errs      = 0;
        timeouts        = 0;
        g_resetn        = 1'b0;
        host_req_valid  = 1'b0;
        host_req_wen    = 1'b0;
        host_req_addr   = '0;
        host_req_wdata  = '0;
        host_rsp_credit = 1'b0;
        instr_ret       = 1'b0;
        inhibit_cy      = 1'b0;
        inhibit_tm      = 1'b1;                // mtime held, reads stay predictable
        inhibit_ir      = 1'b0;
        grant_en        = 1'b0;
        irq_quiet       = 1'b1;
        bg_cnt          = '0;
        repeat (2) @(posedge g_clk);
        g_resetn <= 1'b1;
        grant_en <= 1'b1;

        // Register writes, read back and window faults
        send_req(1'b1, BASE + 32'h0, 32'h0);
        send_req(1'b1, BASE + 32'h4, 32'h0000_5A5A);
        send_req(1'b0, BASE + 32'h4, 32'h0);
        send_req(1'b0, BASE + 32'h0, 32'h0);
        send_req(1'b1, BASE + 32'h8, 32'h1234_5678);
        send_req(1'b1, BASE + 32'hC, 32'h9ABC_DEF0);
        send_req(1'b0, BASE + 32'h8, 32'h0);
        send_req(1'b0, BASE + 32'hC, 32'h0);
        send_req(1'b0, 32'h0000_2000, 32'h0);
        send_req(1'b1, BASE + 32'h10, 32'hDEAD_BEEF);
        send_req(1'b0, BASE + 32'h7FC, 32'h0);
        drain_responses();

        // mtime from zero up to a small mtimecmp
        send_req(1'b1, BASE + 32'h4, 32'h0);
        send_req(1'b1, BASE + 32'h8, 32'h20);
        send_req(1'b1, BASE + 32'hC, 32'h0);
        drain_responses();
        irq_quiet  <= 1'b0;
        inhibit_tm <= 1'b0;
        wait_for_irq();
        send_req(1'b1, BASE + 32'hC, 32'hFFFF_FFFF);
        send_req(1'b1, BASE + 32'h8, 32'hFFFF_FFFF);
        send_req(1'b0, BASE + 32'h8, 32'h0);
        drain_responses();
        repeat (2) @(posedge g_clk);
        irq_quiet  <= 1'b1;
        inhibit_tm <= 1'b1;
        repeat (20) @(posedge g_clk);

        // Random bursts, first with response credits withheld
        send_req(1'b1, BASE + 32'h0, 32'h100);
        send_req(1'b1, BASE + 32'h4, 32'h0);
        drain_responses();
        irq_quiet <= 1'b0;                     // Random writes may lower mtimecmp
        repeat (8) begin
            grant_en <= 1'b0;
            random_burst(1 + ($unsigned($random(seed)) % REQ_DEPTH));
            repeat ($unsigned($random(seed)) % 6) idle_cycle();
            grant_en <= 1'b1;
            random_burst(1 + ($unsigned($random(seed)) % 8));
            drain_responses();
        end

        $display("Errors: %0d value, %0d protocol, %0d timeout",
                 value_errs, proto_errs, timeouts);
        if (value_errs == 0 && proto_errs == 0 && timeouts == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

/* rtl/frv_timer_subsys.sv */
// Timer subsystem top level
// Ingress stage, request buffer and counters block

`timescale 1ns/1ps

module frv_timer_subsys (
    input  logic                      g_clk,
    input  logic                      g_resetn,

    // Host request port
    input  logic                      host_req_valid,
    input  logic                      host_req_wen,
    input  frv_timer_pkg::mmio_addr_t host_req_addr,
    input  frv_timer_pkg::mmio_data_t host_req_wdata,
    output logic                      host_req_credit,

    // Response port
    input  logic                      host_rsp_credit,
    output logic                      rsp_valid,
    output frv_timer_pkg::mmio_data_t rsp_rdata,
    output logic                      rsp_error,

    // Counters and interrupt
    input  logic                      instr_ret,
    input  logic                      inhibit_cy,
    input  logic                      inhibit_tm,
    input  logic                      inhibit_ir,
    output logic                      timer_interrupt,
    output frv_timer_pkg::ctr_t       ctr_time,
    output frv_timer_pkg::ctr_t       ctr_cycle,
    output frv_timer_pkg::ctr_t       ctr_instret
);

    // Ingress to buffer
    logic                      push;
    logic                      push_wen;
    frv_timer_pkg::reg_sel_t   push_sel;
    logic                      push_err;
    frv_timer_pkg::mmio_data_t push_wdata;

    // Buffer to counters
    logic                      fifo_valid;
    logic                      fifo_wen;
    frv_timer_pkg::reg_sel_t   fifo_sel;
    logic                      fifo_err;
    frv_timer_pkg::mmio_data_t fifo_wdata;
    logic                      pop;

    frv_mmio_ingress u_ingress (
        .g_clk          (g_clk),
        .g_resetn       (g_resetn),
        .host_req_valid (host_req_valid),
        .host_req_wen   (host_req_wen),
        .host_req_addr  (host_req_addr),
        .host_req_wdata (host_req_wdata),
        .push           (push),
        .push_wen       (push_wen),
        .push_sel       (push_sel),
        .push_err       (push_err),
        .push_wdata     (push_wdata)
    );

    frv_req_fifo u_req_fifo (
        .g_clk           (g_clk),
        .g_resetn        (g_resetn),
        .push            (push),
        .push_wen        (push_wen),
        .push_sel        (push_sel),
        .push_err        (push_err),
        .push_wdata      (push_wdata),
        .pop             (pop),
        .fifo_valid      (fifo_valid),
        .fifo_wen        (fifo_wen),
        .fifo_sel        (fifo_sel),
        .fifo_err        (fifo_err),
        .fifo_wdata      (fifo_wdata),
        .host_req_credit (host_req_credit)
    );

    frv_counters u_counters (
        .g_clk           (g_clk),
        .g_resetn        (g_resetn),
        .instr_ret       (instr_ret),
        .inhibit_cy      (inhibit_cy),
        .inhibit_tm      (inhibit_tm),
        .inhibit_ir      (inhibit_ir),
        .host_rsp_credit (host_rsp_credit),
        .fifo_valid      (fifo_valid),
        .fifo_wen        (fifo_wen),
        .fifo_sel        (fifo_sel),
        .fifo_err        (fifo_err),
        .fifo_wdata      (fifo_wdata),
        .pop             (pop),
        .rsp_valid       (rsp_valid),
        .rsp_rdata       (rsp_rdata),
        .rsp_error       (rsp_error),
        .timer_interrupt (timer_interrupt),
        .ctr_time        (ctr_time),
        .ctr_cycle       (ctr_cycle),
        .ctr_instret     (ctr_instret)
    );

endmodule

/* rtl/frv_counters.sv */
// Machine timer and performance counters
// mtime, mtimecmp, cycle and instret counters, timer interrupt, and the
// buffered MMIO request server under response credits

`timescale 1ns/1ps

`include "frv_timer_defs.svh"

module frv_counters (
    input  logic                      g_clk,
    input  logic                      g_resetn,

    input  logic                      instr_ret,        // Instruction retired
    input  logic                      inhibit_cy,       // Hold cycle counter
    input  logic                      inhibit_tm,       // Hold mtime
    input  logic                      inhibit_ir,       // Hold instret

    input  logic                      host_rsp_credit,  // One response slot granted

    input  logic                      fifo_valid,
    input  logic                      fifo_wen,
    input  frv_timer_pkg::reg_sel_t   fifo_sel,
    input  logic                      fifo_err,
    input  frv_timer_pkg::mmio_data_t fifo_wdata,
    output logic                      pop,

    output logic                      rsp_valid,
    output frv_timer_pkg::mmio_data_t rsp_rdata,
    output logic                      rsp_error,

    output logic                      timer_interrupt,
    output frv_timer_pkg::ctr_t       ctr_time,
    output frv_timer_pkg::ctr_t       ctr_cycle,
    output frv_timer_pkg::ctr_t       ctr_instret
);

    frv_timer_pkg::credit_t   rsp_credits;
    frv_timer_pkg::ctr_t      mtime;
    frv_timer_pkg::ctr_t      mtimecmp;
    frv_timer_pkg::mmio_data_t rd_data;
    logic                     reg_write;

    // Serve the head request only when a response slot is held
    assign pop = fifo_valid && (rsp_credits != '0);

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            rsp_credits <= '0;
        end else begin
            case ({host_rsp_credit, pop})
                2'b10:   rsp_credits <= rsp_credits + 1'b1;
                2'b01:   rsp_credits <= rsp_credits - 1'b1;
                default: rsp_credits <= rsp_credits;
            endcase
        end
    end

    assign reg_write = pop && fifo_wen && !fifo_err;

    // mtime, a write wins over the increment
    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            mtime <= '0;
        end else if (reg_write && fifo_sel == 2'd0) begin
            mtime <= {mtime[63:32], fifo_wdata};
        end else if (reg_write && fifo_sel == 2'd1) begin
            mtime <= {fifo_wdata, mtime[31:0]};
        end else if (!inhibit_tm) begin
            mtime <= mtime + 64'd1;
        end
    end

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            mtimecmp <= `FRV_MTIMECMP_RESET;
        end else if (reg_write && fifo_sel == 2'd2) begin
            mtimecmp <= {mtimecmp[63:32], fifo_wdata};
        end else if (reg_write && fifo_sel == 2'd3) begin
            mtimecmp <= {fifo_wdata, mtimecmp[31:0]};
        end
    end

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            timer_interrupt <= 1'b0;
        end else begin
            timer_interrupt <= mtime >= mtimecmp;
        end
    end

    // Read mux, values from before the pop edge
    always_comb begin
        case (fifo_sel)
            2'd0:    rd_data = mtime[31:0];
            2'd1:    rd_data = mtime[63:32];
            2'd2:    rd_data = mtimecmp[31:0];
            default: rd_data = mtimecmp[63:32];
        endcase
    end

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            rsp_valid <= 1'b0;
        end else begin
            rsp_valid <= pop;
        end
    end

    always_ff @(posedge g_clk) begin
        if (pop) begin
            rsp_error <= fifo_err;
            rsp_rdata <= (fifo_wen || fifo_err) ? '0 : rd_data;   // Zero on writes and faults
        end
    end

    assign ctr_time = mtime;

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            ctr_cycle <= '0;
        end else if (!inhibit_cy) begin
            ctr_cycle <= ctr_cycle + 64'd1;
        end
    end

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            ctr_instret <= '0;
        end else if (instr_ret && !inhibit_ir) begin
            ctr_instret <= ctr_instret + 64'd1;
        end
    end

    // Host never grants more slots than the block can track
    assert property (@(posedge g_clk) disable iff (!g_resetn)
        rsp_credits <= `FRV_RSP_CREDITS_MAX);

endmodule

/* rtl/frv_req_fifo.sv */
// Request buffer between ingress and the counters block
// Circular buffer whose pops return request credits to the host

`timescale 1ns/1ps

`include "frv_timer_defs.svh"

module frv_req_fifo #(
    parameter int DEPTH = `FRV_REQ_FIFO_DEPTH
) (
    input  logic                      g_clk,
    input  logic                      g_resetn,

    input  logic                      push,
    input  logic                      push_wen,
    input  frv_timer_pkg::reg_sel_t   push_sel,
    input  logic                      push_err,
    input  frv_timer_pkg::mmio_data_t push_wdata,
    input  logic                      pop,

    output logic                      fifo_valid,
    output logic                      fifo_wen,
    output frv_timer_pkg::reg_sel_t   fifo_sel,
    output logic                      fifo_err,
    output frv_timer_pkg::mmio_data_t fifo_wdata,
    output logic                      host_req_credit
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    // Entry storage, one array per field
    logic                      mem_wen   [DEPTH];
    frv_timer_pkg::reg_sel_t   mem_sel   [DEPTH];
    logic                      mem_err   [DEPTH];
    frv_timer_pkg::mmio_data_t mem_wdata [DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;       // Idle or push and pop together
            endcase
        end
    end

    always_ff @(posedge g_clk) begin
        if (push) begin
            mem_wen[wr_ptr]   <= push_wen;
            mem_sel[wr_ptr]   <= push_sel;
            mem_err[wr_ptr]   <= push_err;
            mem_wdata[wr_ptr] <= push_wdata;
        end
    end

    // Head of the buffer
    assign fifo_valid = count != '0;
    assign fifo_wen   = mem_wen[rd_ptr];
    assign fifo_sel   = mem_sel[rd_ptr];
    assign fifo_err   = mem_err[rd_ptr];
    assign fifo_wdata = mem_wdata[rd_ptr];

    // One request credit back per freed entry
    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            host_req_credit <= 1'b0;
        end else begin
            host_req_credit <= pop;
        end
    end

    // The host only sends with a credit in hand, so a full buffer never sees a push
    assert property (@(posedge g_clk) disable iff (!g_resetn)
        push |-> (count < CNT_W'(DEPTH)));

    assert property (@(posedge g_clk) disable iff (!g_resetn)
        pop |-> (count != '0));

endmodule

/* rtl/frv_mmio_ingress.sv */
// MMIO ingress stage
// Registers host requests and decodes the timer window into a register
// select and an error flag

`timescale 1ns/1ps

`include "frv_timer_defs.svh"

module frv_mmio_ingress (
    input  logic                     g_clk,
    input  logic                     g_resetn,

    input  logic                     host_req_valid,
    input  logic                     host_req_wen,
    input  frv_timer_pkg::mmio_addr_t host_req_addr,
    input  frv_timer_pkg::mmio_data_t host_req_wdata,

    output logic                     push,
    output logic                     push_wen,
    output frv_timer_pkg::reg_sel_t  push_sel,
    output logic                     push_err,
    output frv_timer_pkg::mmio_data_t push_wdata
);

    frv_timer_pkg::mmio_addr_t win_offset;
    logic                      in_window;
    logic                      offset_ok;
    logic                      req_err;

    // Offset of the request inside the window
    assign win_offset = host_req_addr & ~`FRV_MMIO_BASE_MASK;

    assign in_window = (host_req_addr & `FRV_MMIO_BASE_MASK) == `FRV_MMIO_BASE_ADDR;
    assign offset_ok = win_offset < 32'd16;    // Only four word registers mapped
    assign req_err   = !(in_window && offset_ok);

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            push <= 1'b0;
        end else begin
            push <= host_req_valid;
        end
    end

    // Faulting requests still go through, their error response keeps order
    always_ff @(posedge g_clk) begin
        if (host_req_valid) begin
            push_wen   <= host_req_wen;
            push_sel   <= win_offset[3:2];     // Word index in the window
            push_err   <= req_err;
            push_wdata <= host_req_wdata;
        end
    end

endmodule

/* rtl/frv_timer_pkg.sv */
// Shared vector types for the timer subsystem
// Address, data, counter, register select and credit widths

package frv_timer_pkg;

    // Byte address of an MMIO request
    typedef logic [31:0] mmio_addr_t;

    // Write or read data word
    typedef logic [31:0] mmio_data_t;

    // One counter or comparator value
    typedef logic [63:0] ctr_t;

    // Register select
    // 0 mtime low, 1 mtime high, 2 mtimecmp low, 3 mtimecmp high
    typedef logic [1:0] reg_sel_t;

    // Credit count, covers the larger of the two credit limits
    typedef logic [3:0] credit_t;

endpackage

/* include/frv_timer_defs.svh */
// Timer subsystem configuration macros
// MMIO window, mtimecmp reset value, buffer depth and response credit limit

`ifndef FRV_TIMER_DEFS_SVH
`define FRV_TIMER_DEFS_SVH

// Timer window in the MMIO space
`define FRV_MMIO_BASE_ADDR  32'h0000_1000
`define FRV_MMIO_BASE_MASK  32'hFFFF_F000   // Fixed bits of the window

// mtimecmp starts at its largest value so no interrupt fires out of reset
`define FRV_MTIMECMP_RESET  64'hFFFF_FFFF_FFFF_FFFF

// Request buffer entries, also the host's initial request credits
`define FRV_REQ_FIFO_DEPTH  4

// Most response credits the counters block can hold at once
`define FRV_RSP_CREDITS_MAX 8

`endif
